// ==== list.f ====
verilog/wrr_pkg.sv
verilog/weight_update_fsm.sv
verilog/credit_bank.sv
verilog/rr_arbiter.sv
verilog/wrr_arbiter.sv
test/wrr_checker.sv
test/tb_wrr_arbiter.sv

// ==== run.sh ====
#!/bin/sh
# Builds the arbiter testbench with Verilator and runs it.
# Exits nonzero on a build error, a run error or a missing pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
        -f list.f --top-module tb_wrr_arbiter -Mdir obj_dir
if [ $? -ne 0 ]; then
        echo "Build error"
        exit 1
fi

out=$(./obj_dir/Vtb_wrr_arbiter)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
        echo "Run error, status $status"
        exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
        exit 0
fi
exit 1

// ==== test/tb_wrr_arbiter.sv ====
// Testbench top for the weighted round-robin arbiter.
// Runs a table of weights, requests and block settings one row at a time.
// The checker counts the grants of each row and closes each test,
// then this module prints the overall result.

`timescale 1ns/1ps

module tb_wrr_arbiter;

        import wrr_pkg::*;

        localparam int NUM_ROWS = 6;
        // First grant limits after a weight change and otherwise
        localparam int FIRST_WAIT_CHANGE = 32;
        localparam int FIRST_WAIT_SAME   = 4;

        logic        clk = 1'b0;
        logic        arst_n;
        logic        block_arb;
        weight_vec_t weights;
        client_vec_t request;
        grant_t      gnt;

        // Checker control and status
        logic        counting;
        logic        expect_quiet;
        int          total;
        int          errors;
        int          timeouts;
        logic        aborted;

        // ----------------------------------------------------------
        // Stimulus table
        // ----------------------------------------------------------

        string                       row_name    [NUM_ROWS];
        weight_vec_t                 row_weights [NUM_ROWS];
        client_vec_t                 row_request [NUM_ROWS];
        logic                        row_block   [NUM_ROWS];
        // Grants to collect; zero runs the row by cycles instead
        int                          row_grants  [NUM_ROWS];
        int                          row_cycles  [NUM_ROWS];
        // Per-client counts checked only when split is set
        logic                        row_split   [NUM_ROWS];
        logic [NUM_CLIENTS-1:0][7:0] row_expect  [NUM_ROWS];

        // 4 ns clock
        always #2 clk = ~clk;

        wrr_arbiter DUT (
                .clk       (clk),
                .arst_n    (arst_n),
                .block_arb (block_arb),
                .weights   (weights),
                .request   (request),
                .gnt       (gnt)
        );

        wrr_checker u_check (
                .clk          (clk),
                .arst_n       (arst_n),
                .request      (request),
                .block_arb    (block_arb),
                .gnt          (gnt),
                .counting     (counting),
                .expect_quiet (expect_quiet),
                .total        (total),
                .errors       (errors)
        );

        task automatic add_row(input int idx, input string name, input weight_vec_t w,
                               input client_vec_t r, input logic b, input int grants,
                               input int cycles, input logic split,
                               input logic [NUM_CLIENTS-1:0][7:0] exp);
                row_name[idx]    = name;
                row_weights[idx] = w;
                row_request[idx] = r;
                row_block[idx]   = b;
                row_grants[idx]  = grants;
                row_cycles[idx]  = cycles;
                row_split[idx]   = split;
                row_expect[idx]  = exp;
        endtask

        // Weights and counts are written client 3 down to client 0
        task automatic load_table();
                // Each replenish round spends the sum of the weights
                add_row(0, "ratio_4211", 16'h1124, 4'hF, 1'b0, 24, 0, 1'b1,
                        {8'd3, 8'd3, 8'd6, 8'd12});
                // Weight zero keeps client 1 out
                add_row(1, "zero_weight", 16'h1203, 4'hF, 1'b0, 18, 0, 1'b1,
                        {8'd3, 8'd6, 8'd0, 8'd9});
                add_row(2, "block", 16'h1203, 4'hF, 1'b1, 0, 20, 1'b0, '0);
                add_row(3, "release", 16'h1203, 4'hF, 1'b0, 6, 0, 1'b0, '0);
                add_row(4, "single_req", 16'h1203, 4'b0100, 1'b0, 8, 0, 1'b1,
                        {8'd0, 8'd8, 8'd0, 8'd0});
                add_row(5, "weight_change", 16'h1412, 4'hF, 1'b0, 24, 0, 1'b1,
                        {8'd3, 8'd12, 8'd3, 8'd6});
        endtask

        // ----------------------------------------------------------
        // Row sequencing
        // ----------------------------------------------------------

        task automatic run_row(input int i);
                logic change;
                logic got;
                int   n;
                int   limit;

                @(posedge clk);
                change = (row_weights[i] != weights);
                weights      <= row_weights[i];
                request      <= row_request[i];
                block_arb    <= row_block[i];
                expect_quiet <= change;
                // Skip the grant issued from the previous inputs
                @(posedge clk);
                if (change) begin
                        // One more grant may slip out before the drain
                        @(posedge clk);
                end
                counting <= 1'b1;
                if (row_grants[i] > 0) begin
                        limit = change ? FIRST_WAIT_CHANGE : FIRST_WAIT_SAME;
                        got   = 1'b0;
                        n     = 0;
                        while (!got && n < limit) begin
                                @(negedge clk);
                                got = gnt.valid;
                                n++;
                        end
                        if (!got) begin
                                $display("ERROR: test %s saw no grant within %0d cycles",
                                         row_name[i], limit);
                                timeouts++;
                                aborted = 1'b1;
                                return;
                        end
                        // Collect the rest of the grants
                        limit = 8 * row_grants[i] + 32;
                        n     = 0;
                        do begin
                                @(posedge clk);
                                n++;
                        end while (total < row_grants[i] && n < limit);
                        if (total < row_grants[i]) begin
                                $display("ERROR: test %s got only %0d of %0d grants in time",
                                         row_name[i], total, row_grants[i]);
                                timeouts++;
                                aborted = 1'b1;
                                return;
                        end
                end else begin
                        repeat (row_cycles[i]) @(posedge clk);
                end
                counting <= 1'b0;
                u_check.finish_test(row_name[i], row_grants[i], row_split[i], row_expect[i]);
        endtask

        initial begin
                arst_n       = 1'b0;
                block_arb    = 1'b0;
                weights      = {NUM_CLIENTS{WEIGHT_W'(1)}};
                // All clients request through reset
                request      = '1;
                counting     = 1'b0;
                expect_quiet = 1'b0;
                timeouts     = 0;
                aborted      = 1'b0;
                load_table();
                repeat (3) @(posedge clk);
                arst_n <= 1'b1;
                for (int i = 0; i < NUM_ROWS && !aborted; i++) begin
                        run_row(i);
                end
                @(posedge clk);
                u_check.report_counts(timeouts);
                if (timeouts == 0 && errors == 0) begin
                        $display("Simulation passed");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// ==== test/wrr_checker.sv ====
// Grant checker for the weighted round-robin arbiter testbench.
// Samples the DUT on the falling clock edge, where all ports are stable.
// Every grant is checked for a clean one-hot encoding, a matching request,
// and the reset and block rules. Grants are counted per client while the
// testbench raises counting, and the testbench closes each test by
// calling finish_test with the expected counts.

`timescale 1ns/1ps

module wrr_checker (
        input  logic                 clk,
        input  logic                 arst_n,
        input  wrr_pkg::client_vec_t request,
        input  logic                 block_arb,
        input  wrr_pkg::grant_t      gnt,
        input  logic                 counting,
        input  logic                 expect_quiet,
        output int                   total,
        output int                   errors
);

        import wrr_pkg::*;

        // Idle cycles a new weight set must leave before its first grant
        localparam int QUIET_MIN = 8;

        int          counts [NUM_CLIENTS] = '{default: 0};
        int          r_total = 0;
        int          err_count = 0;
        int          row_errors = 0;
        int          tests_run = 0;
        int          tests_failed = 0;
        // Consecutive samples without a valid grant
        int          quiet = 0;
        client_vec_t prev_request = '0;
        logic        prev_block = 1'b0;
        logic        prev_arst_n = 1'b0;

        assign total  = r_total;
        assign errors = err_count;

        task automatic flag_error(input string what);
                $display("ERROR: %s at %0t", what, $time);
                err_count++;
                row_errors++;
        endtask

        // ----------------------------------------------------------
        // Per-cycle grant checks and counting
        // ----------------------------------------------------------

        always @(negedge clk) begin
                if (!arst_n || !prev_arst_n) begin
                        // Quiet during reset and the first cycle after it
                        if (gnt.valid) begin
                                flag_error("grant valid during or right after reset");
                        end
                end else if (gnt.valid) begin
                        if ($countones(gnt.onehot) != 1) begin
                                flag_error("grant onehot does not have exactly one bit set");
                        end else if (gnt.onehot != (client_vec_t'(1) << gnt.id)) begin
                                flag_error("grant id does not match its onehot bit");
                        end
                        // Registered grant answers the request of the cycle before
                        if (!prev_request[gnt.id]) begin
                                flag_error("grant to a client that was not requesting");
                        end
                        if (prev_block) begin
                                flag_error("grant while block_arb was held");
                        end
                        if (counting) begin
                                if (expect_quiet && r_total == 0 && quiet < QUIET_MIN) begin
                                        flag_error("first grant came too soon after a weight change");
                                end
                                counts[gnt.id] <= counts[gnt.id] + 1;
                                r_total        <= r_total + 1;
                        end
                end
                quiet        <= gnt.valid ? 0 : quiet + 1;
                prev_request <= request;
                prev_block   <= block_arb;
                prev_arst_n  <= arst_n;
        end

        // ----------------------------------------------------------
        // Test results
        // ----------------------------------------------------------

        task automatic finish_test(input string name, input int exp_total, input logic split,
                                   input logic [NUM_CLIENTS-1:0][7:0] exp_cnt);
                logic bad_split;

                bad_split = 1'b0;
                for (int i = 0; i < NUM_CLIENTS; i++) begin
                        if (split && counts[i] != int'(exp_cnt[i])) begin
                                bad_split = 1'b1;
                        end
                end
                tests_run++;
                if (bad_split) begin
                        $display("MISMATCH %s expected %0d %0d %0d %0d actual %0d %0d %0d %0d",
                                 name, exp_cnt[0], exp_cnt[1], exp_cnt[2], exp_cnt[3],
                                 counts[0], counts[1], counts[2], counts[3]);
                end else if (r_total != exp_total) begin
                        $display("MISMATCH %s expected %0d grants actual %0d",
                                 name, exp_total, r_total);
                end else if (row_errors != 0) begin
                        $display("FAIL %s with %0d grant check errors", name, row_errors);
                end else begin
                        $display("PASS %s with %0d grants", name, r_total);
                end
                if (bad_split || r_total != exp_total) begin
                        err_count++;
                end
                if (bad_split || r_total != exp_total || row_errors != 0) begin
                        tests_failed++;
                end
                // Fresh counts for the next test
                for (int i = 0; i < NUM_CLIENTS; i++) begin
                        counts[i] <= 0;
                end
                r_total    <= 0;
                row_errors = 0;
        endtask

        task automatic report_counts(input int timeouts);
                $display("Tests %0d, passed %0d, failed %0d, errors %0d, timeouts %0d",
                         tests_run, tests_run - tests_failed, tests_failed, err_count, timeouts);
        endtask

endmodule

// ==== verilog/credit_bank.sv ====
// Credit bank of the weighted round-robin arbiter.
// Keeps one credit counter per client, decides which requests are
// eligible and triggers a global replenish once every requesting client
// has run dry. Its output is the filtered request vector that feeds the
// base round-robin arbiter one register stage ahead of the grant.

`timescale 1ns/1ps

module credit_bank (
        input  logic                 clk,
        input  logic                 arst_n,
        input  wrr_pkg::weight_vec_t active_weights,
        input  logic                 arb_enable,
        input  logic                 reload,
        input  wrr_pkg::client_vec_t request,
        input  logic                 block_arb,
        input  wrr_pkg::grant_t      gnt,
        output wrr_pkg::client_vec_t arb_req
);

        import wrr_pkg::*;

        // One counter per client, client 0 in the low nibble
        weight_vec_t r_credit;

        client_vec_t w_req_post;
        client_vec_t w_valid_client;
        client_vec_t w_has_crd;
        client_vec_t w_eligible;
        client_vec_t w_more_than_one;
        logic        w_global_replenish;
        logic        w_multiple_eligible;

        // External block removes every request
        assign w_req_post = block_arb ? '0 : request;

        // ----------------------------------------------------------
        // Per-client credit status
        // ----------------------------------------------------------

        always_comb begin
                for (int i = 0; i < NUM_CLIENTS; i++) begin
                        // Weight zero disables the client for good
                        w_valid_client[i]  = (active_weights[i] != '0);
                        w_has_crd[i]       = (r_credit[i] != '0) && w_valid_client[i];
                        w_more_than_one[i] = (r_credit[i] > WEIGHT_W'(1));
                end
        end

        // Nobody requesting still holds credit, so refill everyone
        assign w_global_replenish = arb_enable && (|w_req_post) &&
                                    !(|(w_req_post & w_has_crd));

        // Requesting with credit, or any nonzero weight on a replenish
        assign w_eligible = w_req_post &
                            (w_has_crd | (w_global_replenish ? w_valid_client : '0));

        assign w_multiple_eligible = ($countones(w_eligible) > 1);

        // ----------------------------------------------------------
        // Request masking
        // ----------------------------------------------------------

        // Last winner steps aside when others are waiting.
        // A lone client with credit to spare keeps its request
        assign arb_req = (w_eligible & ~gnt.onehot) |
                         ({NUM_CLIENTS{!w_multiple_eligible}} & w_eligible & w_more_than_one);

        // ----------------------------------------------------------
        // Credit counters
        // ----------------------------------------------------------

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        // One credit each, matching the reset weights
                        r_credit <= {NUM_CLIENTS{WEIGHT_W'(1)}};
                end else begin
                        for (int i = 0; i < NUM_CLIENTS; i++) begin
                                if (reload || w_global_replenish) begin
                                        // Zero weight reloads to zero credit
                                        r_credit[i] <= active_weights[i];
                                end else if (gnt.valid && gnt.onehot[i] &&
                                             (r_credit[i] != '0)) begin
                                        // Grant completes in its own cycle
                                        r_credit[i] <= r_credit[i] - WEIGHT_W'(1);
                                end
                        end
                end
        end

endmodule

// ==== verilog/rr_arbiter.sv ====
// Base round-robin arbiter below the credit bank.
// Picks the first set request at or after a rotating pointer and
// registers the winner as a one-hot grant with its encoded id.
// The pointer moves just past each winner, and nothing is granted
// while arb_enable is low.

`timescale 1ns/1ps

module rr_arbiter (
        input  logic                 clk,
        input  logic                 arst_n,
        input  wrr_pkg::client_vec_t arb_req,
        input  logic                 arb_enable,
        output wrr_pkg::grant_t      gnt
);

        import wrr_pkg::*;

        // Highest priority client for the next pick
        logic [CLIENT_ID_W-1:0] r_ptr;
        grant_t                 r_gnt;

        logic                   w_found;
        logic [CLIENT_ID_W-1:0] w_pick_id;
        client_vec_t            w_pick_onehot;

        // ----------------------------------------------------------
        // Rotating priority search
        // ----------------------------------------------------------

        always_comb begin
                logic [CLIENT_ID_W-1:0] idx;

                w_found   = 1'b0;
                w_pick_id = '0;
                idx       = '0;
                for (int i = 0; i < NUM_CLIENTS; i++) begin
                        // Index wraps on its own since the count is a power of two
                        idx = r_ptr + CLIENT_ID_W'(i);
                        if (!w_found && arb_req[idx]) begin
                                w_found   = 1'b1;
                                w_pick_id = idx;
                        end
                end
        end

        // Decode the winner back to one-hot
        assign w_pick_onehot = w_found ? (client_vec_t'(1) << w_pick_id) : '0;

        // ----------------------------------------------------------
        // Grant register and pointer
        // ----------------------------------------------------------

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        r_ptr <= '0;
                        r_gnt <= '0;
                end else begin
                        if (arb_enable && w_found) begin
                                r_gnt.valid  <= 1'b1;
                                r_gnt.onehot <= w_pick_onehot;
                                r_gnt.id     <= w_pick_id;
                                // Winner drops to lowest priority
                                r_ptr        <= w_pick_id + CLIENT_ID_W'(1);
                        end else begin
                                // Grant is a single-cycle pulse
                                r_gnt <= '0;
                        end
                end
        end

        assign gnt = r_gnt;

endmodule

// ==== verilog/weight_update_fsm.sv ====
// Weight update sequencer for the weighted round-robin arbiter.
// Watches the incoming weights and, on any change, walks through
// drain, update and stabilize before letting arbitration resume.
// The active weights are held in a shadow register and swapped in a
// single cycle so the credit logic only ever sees a complete set.

`timescale 1ns/1ps

module weight_update_fsm (
        input  logic                clk,
        input  logic                arst_n,
        input  wrr_pkg::weight_vec_t weights,
        output wrr_pkg::weight_vec_t active_weights,
        output logic                arb_enable,
        output logic                reload
);

        import wrr_pkg::*;

        weight_state_t          r_state;
        logic [SEQ_TIMER_W-1:0] r_timer;
        // Shadow copy of the weights in use
        weight_vec_t            r_active;
        logic                   w_change;

        // Any difference in any client starts a new sequence
        assign w_change = (weights != r_active);

        // ----------------------------------------------------------
        // Sequencer
        // ----------------------------------------------------------

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        r_state  <= W_IDLE;
                        r_timer  <= '0;
                        // Weight 1 per client out of reset
                        r_active <= {NUM_CLIENTS{WEIGHT_W'(1)}};
                end else begin
                        case (r_state)
                                W_IDLE: begin
                                        if (w_change) begin
                                                r_state <= W_DRAIN;
                                                r_timer <= SEQ_TIMER_W'(DRAIN_CYCLES);
                                        end
                                end
                                W_DRAIN: begin
                                        // Let the grant in flight settle
                                        if (r_timer == '0) begin
                                                r_state <= W_UPDATE;
                                        end else begin
                                                r_timer <= r_timer - 1'b1;
                                        end
                                end
                                W_UPDATE: begin
                                        // Atomic swap of the whole weight set
                                        r_active <= weights;
                                        r_state  <= W_STABILIZE;
                                        r_timer  <= SEQ_TIMER_W'(STABILIZE_CYCLES);
                                end
                                W_STABILIZE: begin
                                        // Credits reload from the new set here
                                        if (r_timer == '0) begin
                                                r_state <= W_IDLE;
                                        end else begin
                                                r_timer <= r_timer - 1'b1;
                                        end
                                end
                                default: begin
                                        // Illegal encoding, go back to idle
                                        r_state <= W_IDLE;
                                        r_timer <= '0;
                                end
                        endcase
                end
        end

        // ----------------------------------------------------------
        // Outputs
        // ----------------------------------------------------------

        assign active_weights = r_active;
        // Grants only in idle
        assign arb_enable     = (r_state == W_IDLE);
        // Credit reload while stabilizing
        assign reload         = (r_state == W_STABILIZE);

endmodule

// ==== verilog/wrr_arbiter.sv ====
// Top level of the four-client weighted round-robin arbiter.
// The weight sequencer feeds active weights to the credit bank, which
// filters the requests for the base round-robin arbiter. The registered
// grant goes out on gnt and loops back to the credit bank.

`timescale 1ns/1ps

module wrr_arbiter (
        input  logic                 clk,
        input  logic                 arst_n,
        input  logic                 block_arb,
        input  wrr_pkg::weight_vec_t weights,
        input  wrr_pkg::client_vec_t request,
        output wrr_pkg::grant_t      gnt
);

        import wrr_pkg::*;

        // ----------------------------------------------------------
        // Internal connections
        // ----------------------------------------------------------

        weight_vec_t w_active_weights;
        logic        w_arb_enable;
        logic        w_reload;
        // Credit filtered requests into the base arbiter
        client_vec_t w_arb_req;

        // Weight change sequencing and shadow weights
        weight_update_fsm u_weight_fsm (
                .clk            (clk),
                .arst_n         (arst_n),
                .weights        (weights),
                .active_weights (w_active_weights),
                .arb_enable     (w_arb_enable),
                .reload         (w_reload)
        );

        // Credits, eligibility and fairness masking
        credit_bank u_credit_bank (
                .clk            (clk),
                .arst_n         (arst_n),
                .active_weights (w_active_weights),
                .arb_enable     (w_arb_enable),
                .reload         (w_reload),
                .request        (request),
                .block_arb      (block_arb),
                .gnt            (gnt),
                .arb_req        (w_arb_req)
        );

        // Registered round-robin pick
        rr_arbiter u_rr_arbiter (
                .clk        (clk),
                .arst_n     (arst_n),
                .arb_req    (w_arb_req),
                .arb_enable (w_arb_enable),
                .gnt        (gnt)
        );

endmodule

// ==== verilog/wrr_pkg.sv ====
// Shared constants and types for the weighted round-robin arbiter.
// Every RTL file imports this package inside its module body and uses
// scoped names in its port list.
// It holds the client count, weight width, sequencer timing and the
// grant struct that leaves the top level.

package wrr_pkg;

        // ----------------------------------------------------------
        // Sizes
        // ----------------------------------------------------------

        // Number of requesting clients, kept a power of two
        localparam int NUM_CLIENTS = 4;
        // Width of a client index
        localparam int CLIENT_ID_W = 2;
        // Width of one weight and one credit counter
        localparam int WEIGHT_W = 4;

        // ----------------------------------------------------------
        // Weight update sequencer timing
        // ----------------------------------------------------------

        // Drain lasts DRAIN_CYCLES+1 cycles
        localparam int DRAIN_CYCLES = 2;
        // Stabilize lasts STABILIZE_CYCLES+1 cycles
        localparam int STABILIZE_CYCLES = 3;
        // Down-counter wide enough for the larger of the two
        localparam int SEQ_TIMER_W = 2;

        // ----------------------------------------------------------
        // Types
        // ----------------------------------------------------------

        // One bit per client, used for requests, masks and grants
        typedef logic [NUM_CLIENTS-1:0] client_vec_t;

        // Single weight or credit value
        typedef logic [WEIGHT_W-1:0] weight_t;

        // All weights, client 0 in the low nibble
        typedef weight_t [NUM_CLIENTS-1:0] weight_vec_t;

        // Grant output, a one-cycle pulse
        typedef struct packed {
                logic                   valid;
                client_vec_t            onehot;
                logic [CLIENT_ID_W-1:0] id;
        } grant_t;

        // One-hot states of the weight update sequencer
        typedef enum logic [3:0] {
                W_IDLE      = 4'b0001,
                W_DRAIN     = 4'b0010,
                W_UPDATE    = 4'b0100,
                W_STABILIZE = 4'b1000
        } weight_state_t;

endpackage
